//--- audioPkg.sv
package audioPkg;

    // sample and control widths.
    typedef logic signed [15:0] sample_t;
    typedef logic signed [11:0] delta_t;
    typedef logic [23:0] pos_t;
    typedef logic [5:0] romAddr_t;
    typedef logic [7:0] volume_t;

    // control port select codes.
    typedef enum logic [3:0] {
        REG_START_ADDR   = 4'd1,
        REG_SAMPLE_COUNT = 4'd2,
        REG_LOOP_START   = 4'd3,
        REG_LOOP_END     = 4'd4,
        REG_CUR_POS      = 4'd5,
        REG_LAST_SAMPLE  = 4'd6,
        REG_VOLUME       = 4'd7,
        REG_LOOPING      = 4'd8,
        REG_MONO         = 4'd10,
        REG_LEFT         = 4'd11,
        REG_PLAYING      = 4'd9
    } regSel_t;

    // clk_25mhz cycles per half bit clock.
    localparam int BCLK_HALF = 6;

    localparam int SLOT_BITS = 16;
    localparam int FRAME_BITS = 2 * SLOT_BITS; // left plus right.

    localparam int ROM_DEPTH = 64;

    // volume of 128 is unity gain.
    localparam int VOL_SHIFT = 7;

    localparam int REG_DATA_W = 24;

endpackage

//--- channelRegs.sv
`timescale 1ns/1ps
module channelRegs import audioPkg::*; (
    input  logic                  clk_25mhz,
    input  logic                  i_arstN,
    input  logic                  i_regWe,
    input  regSel_t               i_regSel,
    input  logic [REG_DATA_W-1:0] i_regData,
    output romAddr_t              o_startAddr,
    output pos_t                  o_sampleCount,
    output pos_t                  o_loopStart,
    output pos_t                  o_loopEnd,
    output volume_t               o_volume,
    output logic                  o_looping,
    output logic                  o_mono,
    output logic                  o_left,
    output logic                  o_posLoad,
    output pos_t                  o_posValue,
    output logic                  o_lastLoad,
    output sample_t               o_lastValue,
    output logic                  o_playSet,
    output logic                  o_playValue
);

    always_ff @(posedge clk_25mhz or negedge i_arstN) begin
        if (!i_arstN) begin
            o_startAddr   <= '0;
            o_sampleCount <= '0;
            o_loopStart   <= '0;
            o_loopEnd     <= '0;
            o_volume      <= '0;
            o_looping     <= 1'b0;
            o_mono        <= 1'b0;
            o_left        <= 1'b0;
            o_posLoad     <= 1'b0;
            o_posValue    <= '0;
            o_lastLoad    <= 1'b0;
            o_lastValue   <= '0;
            o_playSet     <= 1'b0;
            o_playValue   <= 1'b0;
        end else begin
            o_posLoad  <= 1'b0; // pulses last one cycle.
            o_lastLoad <= 1'b0;
            o_playSet  <= 1'b0;
            if (i_regWe) begin
                case (i_regSel)
                    REG_START_ADDR:   o_startAddr <= i_regData[5:0];
                    REG_SAMPLE_COUNT: o_sampleCount <= i_regData;
                    REG_LOOP_START:   o_loopStart <= i_regData;
                    REG_LOOP_END:     o_loopEnd <= i_regData;
                    REG_VOLUME:       o_volume <= i_regData[7:0];
                    REG_LOOPING:      o_looping <= i_regData[0];
                    REG_MONO:         o_mono <= i_regData[0];
                    REG_LEFT:         o_left <= i_regData[0];
                    // running state lives in the voice.
                    REG_CUR_POS: begin
                        o_posLoad  <= 1'b1;
                        o_posValue <= i_regData;
                    end
                    REG_LAST_SAMPLE: begin
                        o_lastLoad  <= 1'b1;
                        o_lastValue <= i_regData[15:0];
                    end
                    REG_PLAYING: begin
                        o_playSet   <= 1'b1;
                        o_playValue <= i_regData[0];
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- sampleRom.sv
`timescale 1ns/1ps
module sampleRom import audioPkg::*; (
    input  logic     clk_25mhz,
    input  romAddr_t i_addr,
    output delta_t   o_delta
);

    // one signed delta per word.
    delta_t mem [ROM_DEPTH];

    initial begin
        $readmemh("deltas.hex", mem);
    end

    // registered read, delta valid the cycle after the address.
    always_ff @(posedge clk_25mhz) begin
        o_delta <= mem[i_addr];
    end

endmodule

//--- channelVoice.sv
`timescale 1ns/1ps
module channelVoice import audioPkg::*; (
    input  logic     clk_25mhz,
    input  logic     i_arstN,
    input  romAddr_t i_startAddr,
    input  pos_t     i_sampleCount,
    input  pos_t     i_loopStart,
    input  pos_t     i_loopEnd,
    input  volume_t  i_volume,
    input  logic     i_looping,
    input  logic     i_mono,
    input  logic     i_left,
    input  logic     i_posLoad,
    input  pos_t     i_posValue,
    input  logic     i_lastLoad,
    input  sample_t  i_lastValue,
    input  logic     i_playSet,
    input  logic     i_playValue,
    input  logic     i_frameReq,
    output romAddr_t o_romAddr,
    input  delta_t   i_delta,
    output sample_t  o_leftSample,
    output sample_t  o_rightSample,
    output logic     o_playing
);

    pos_t    position;
    sample_t lastSample;
    sample_t outSample;
    logic    playing;

    logic s1Valid; // delta on the ROM output.
    logic s1Play;
    logic s2Valid; // lastSample updated.
    logic s2Play;

    logic signed [16:0] accSum;
    logic signed [24:0] product;
    logic signed [24:0] scaled;
    sample_t            accSat;
    sample_t            scaledSat;

    assign o_romAddr = i_startAddr + position[5:0]; // wraps at 64.

    always_comb begin
        accSum = {lastSample[15], lastSample} + {{5{i_delta[11]}}, i_delta};
        if (accSum[16] != accSum[15]) begin
            accSat = accSum[16] ? 16'sh8000 : 16'sh7fff;
        end else begin
            accSat = accSum[15:0];
        end
    end

    always_comb begin
        product = lastSample * $signed({1'b0, i_volume});
        scaled  = product >>> VOL_SHIFT;
        if (scaled > 25'sd32767) begin
            scaledSat = 16'sh7fff;
        end else if (scaled < -25'sd32768) begin
            scaledSat = 16'sh8000;
        end else begin
            scaledSat = scaled[15:0];
        end
    end

    always_ff @(posedge clk_25mhz or negedge i_arstN) begin
        if (!i_arstN) begin
            s1Valid   <= 1'b0;
            s1Play    <= 1'b0;
            s2Valid   <= 1'b0;
            s2Play    <= 1'b0;
            outSample <= '0;
        end else begin
            s1Valid <= i_frameReq;
            s1Play  <= playing;
            s2Valid <= s1Valid;
            s2Play  <= s1Play;
            if (s2Valid) begin
                outSample <= s2Play ? scaledSat : '0; // silence once stopped.
            end
        end
    end

    always_ff @(posedge clk_25mhz or negedge i_arstN) begin
        if (!i_arstN) begin
            lastSample <= '0;
        end else if (i_lastLoad) begin
            lastSample <= i_lastValue;
        end else if (s1Valid && s1Play) begin
            lastSample <= accSat;
        end
    end

    // position stepping and end of playback.
    always_ff @(posedge clk_25mhz or negedge i_arstN) begin
        if (!i_arstN) begin
            position <= '0;
            playing  <= 1'b0;
        end else begin
            if (s2Valid && s2Play) begin
                if (i_looping && position == i_loopEnd) begin
                    position <= i_loopStart;
                end else if (!i_looping && position + 1'b1 == i_sampleCount) begin
                    playing <= 1'b0; // position holds.
                end else begin
                    position <= position + 1'b1;
                end
            end
            if (i_posLoad) position <= i_posValue; // writes win.
            if (i_playSet) playing <= i_playValue;
        end
    end

    assign o_leftSample  = (i_mono || i_left) ? outSample : '0;
    assign o_rightSample = (i_mono || !i_left) ? outSample : '0;
    assign o_playing     = playing;

endmodule

//--- i2sTransmitter.sv
`timescale 1ns/1ps
module i2sTransmitter import audioPkg::*; (
    input  logic    clk_25mhz,
    input  logic    i_arstN,
    input  sample_t i_leftSample,
    input  sample_t i_rightSample,
    output logic    o_frameReq,
    output logic    o_bclk,
    output logic    o_lrclk,
    output logic    o_din
);

    typedef enum logic {
        ST_LEFT,
        ST_RIGHT
    } slotState_t;

    localparam int DIV_W = $clog2(BCLK_HALF);
    localparam int BIT_W = $clog2(FRAME_BITS);

    slotState_t             slotState;
    logic [DIV_W-1:0]       divCnt;
    logic [BIT_W-1:0]       bitCnt;
    logic [BIT_W-1:0]       nextBit;
    logic                   bclkFall;
    sample_t                leftHold;
    sample_t                rightHold;
    logic [SLOT_BITS-1:0]   shiftReg;

    assign bclkFall = (divCnt == DIV_W'(BCLK_HALF - 1)) && o_bclk;
    assign nextBit  = bitCnt + 1'b1; // 32 periods wrap naturally.

    always_ff @(posedge clk_25mhz or negedge i_arstN) begin
        if (!i_arstN) begin
            divCnt <= '0;
            o_bclk <= 1'b0;
        end else if (divCnt == DIV_W'(BCLK_HALF - 1)) begin
            divCnt <= '0;
            o_bclk <= ~o_bclk;
        end else begin
            divCnt <= divCnt + 1'b1;
        end
    end

    // slot state and data move on falling bclk only.
    always_ff @(posedge clk_25mhz or negedge i_arstN) begin
        if (!i_arstN) begin
            bitCnt     <= '0;
            slotState  <= ST_LEFT;
            o_frameReq <= 1'b0;
            o_din      <= 1'b0;
            shiftReg   <= '0;
        end else begin
            o_frameReq <= bclkFall && nextBit == '0;
            if (bclkFall) begin
                bitCnt <= nextBit;
                if (nextBit == '0) slotState <= ST_LEFT;
                if (nextBit == BIT_W'(SLOT_BITS)) slotState <= ST_RIGHT;
                // msb goes out one period after lrclk changes.
                if (nextBit == BIT_W'(1)) begin
                    o_din    <= leftHold[SLOT_BITS-1];
                    shiftReg <= {leftHold[SLOT_BITS-2:0], 1'b0};
                end else if (nextBit == BIT_W'(SLOT_BITS + 1)) begin
                    o_din    <= rightHold[SLOT_BITS-1];
                    shiftReg <= {rightHold[SLOT_BITS-2:0], 1'b0};
                end else begin
                    o_din    <= shiftReg[SLOT_BITS-1];
                    shiftReg <= {shiftReg[SLOT_BITS-2:0], 1'b0};
                end
            end
        end
    end

    // both slots captured at the start of the left slot.
    always_ff @(posedge clk_25mhz or negedge i_arstN) begin
        if (!i_arstN) begin
            leftHold  <= '0;
            rightHold <= '0;
        end else if (o_frameReq) begin
            leftHold  <= i_leftSample;
            rightHold <= i_rightSample;
        end
    end

    assign o_lrclk = (slotState == ST_RIGHT);

endmodule

//--- audioChannelTop.sv
`timescale 1ns/1ps
module audioChannelTop import audioPkg::*; (
    input  logic                  clk_25mhz,
    input  logic                  i_arstN,
    input  logic                  i_regWe,
    input  regSel_t               i_regSel,
    input  logic [REG_DATA_W-1:0] i_regData,
    output logic                  audio_bclk,
    output logic                  audio_lrclk,
    output logic                  audio_din,
    output logic                  o_playing
);

    romAddr_t startAddr;
    pos_t     sampleCount;
    pos_t     loopStart;
    pos_t     loopEnd;
    volume_t  volume;
    logic     looping;
    logic     mono;
    logic     left;
    logic     posLoad;
    pos_t     posValue;
    logic     lastLoad;
    sample_t  lastValue;
    logic     playSet;
    logic     playValue;
    logic     frameReq;
    romAddr_t romAddr;
    delta_t   delta;
    sample_t  leftSample;
    sample_t  rightSample;

    channelRegs u_regs (
        .clk_25mhz     (clk_25mhz),
        .i_arstN       (i_arstN),
        .i_regWe       (i_regWe),
        .i_regSel      (i_regSel),
        .i_regData     (i_regData),
        .o_startAddr   (startAddr),
        .o_sampleCount (sampleCount),
        .o_loopStart   (loopStart),
        .o_loopEnd     (loopEnd),
        .o_volume      (volume),
        .o_looping     (looping),
        .o_mono        (mono),
        .o_left        (left),
        .o_posLoad     (posLoad),
        .o_posValue    (posValue),
        .o_lastLoad    (lastLoad),
        .o_lastValue   (lastValue),
        .o_playSet     (playSet),
        .o_playValue   (playValue)
    );

    channelVoice u_voice (
        .clk_25mhz     (clk_25mhz),
        .i_arstN       (i_arstN),
        .i_startAddr   (startAddr),
        .i_sampleCount (sampleCount),
        .i_loopStart   (loopStart),
        .i_loopEnd     (loopEnd),
        .i_volume      (volume),
        .i_looping     (looping),
        .i_mono        (mono),
        .i_left        (left),
        .i_posLoad     (posLoad),
        .i_posValue    (posValue),
        .i_lastLoad    (lastLoad),
        .i_lastValue   (lastValue),
        .i_playSet     (playSet),
        .i_playValue   (playValue),
        .i_frameReq    (frameReq),
        .o_romAddr     (romAddr),
        .i_delta       (delta),
        .o_leftSample  (leftSample),
        .o_rightSample (rightSample),
        .o_playing     (o_playing)
    );

    sampleRom u_rom (
        .clk_25mhz (clk_25mhz),
        .i_addr    (romAddr),
        .o_delta   (delta)
    );

    i2sTransmitter u_i2s (
        .clk_25mhz     (clk_25mhz),
        .i_arstN       (i_arstN),
        .i_leftSample  (leftSample),
        .i_rightSample (rightSample),
        .o_frameReq    (frameReq),
        .o_bclk        (audio_bclk),
        .o_lrclk       (audio_lrclk),
        .o_din         (audio_din)
    );

endmodule

//--- audioChannel_checker.sv
`timescale 1ns/1ps
module audioChannel_checker import audioPkg::*; (
    input logic clk_25mhz,
    input logic i_arstN,
    input logic i_bclk,
    input logic i_lrclk,
    input logic i_din,
    input logic i_playing,
    input logic i_frameReq
);

    int   failCount = 0;
    logic lastBclk;
    int   holdCnt; // cycles bclk has held its level.

    always_ff @(posedge clk_25mhz or negedge i_arstN) begin
        if (!i_arstN) begin
            lastBclk <= 1'b0;
            holdCnt  <= 0;
        end else begin
            lastBclk <= i_bclk;
            holdCnt  <= (i_bclk != lastBclk) ? 1 : holdCnt + 1;
        end
    end

    assert property (@(posedge clk_25mhz) disable iff (!i_arstN)
        (i_bclk != lastBclk) |-> (holdCnt == BCLK_HALF))
        else begin
            failCount++;
            $error("bit clock level held %0d cycles instead of %0d", holdCnt, BCLK_HALF);
        end

    // word clock and data move with the falling bit clock only.
    assert property (@(posedge clk_25mhz) disable iff (!i_arstN)
        $changed(i_lrclk) |-> $fell(i_bclk))
        else begin
            failCount++;
            $error("audio_lrclk changed away from a falling bit clock edge");
        end

    assert property (@(posedge clk_25mhz) disable iff (!i_arstN)
        $changed(i_din) |-> $fell(i_bclk))
        else begin
            failCount++;
            $error("audio_din changed away from a falling bit clock edge");
        end

    assert property (@(posedge clk_25mhz) disable iff (!i_arstN)
        i_frameReq |-> (!i_lrclk ##1 !i_frameReq))
        else begin
            failCount++;
            $error("frame request is not a single pulse in the left slot");
        end

    assert property (@(posedge clk_25mhz)
        !i_arstN |-> (!i_bclk && !i_lrclk && !i_din && !i_playing && !i_frameReq))
        else begin
            failCount++;
            $error("outputs are not low while reset is asserted");
        end

endmodule

bind audioChannelTop audioChannel_checker u_checker (
    .clk_25mhz  (clk_25mhz),
    .i_arstN    (i_arstN),
    .i_bclk     (audio_bclk),
    .i_lrclk    (audio_lrclk),
    .i_din      (audio_din),
    .i_playing  (o_playing),
    .i_frameReq (frameReq)
);

//--- tb_audioChannel.sv
`timescale 1ns/1ps
module tb_audioChannel import audioPkg::*; ();

    localparam int FRAME_TIMEOUT = 1000; // one frame is 384 cycles.

    logic                  clk_25mhz;
    logic                  i_arstN;
    logic                  i_regWe;
    regSel_t               i_regSel;
    logic [REG_DATA_W-1:0] i_regData;
    logic                  audio_bclk;
    logic                  audio_lrclk;
    logic                  audio_din;
    logic                  o_playing;

    int errors = 0;

    // i2s receiver state.
    logic [15:0] shiftIn = '0;
    logic [15:0] gotLeft = '0;
    logic [15:0] gotRight = '0;
    logic        prevLr = 1'b0;
    bit          slotSync = 1'b0;
    int          bitsInSlot = 0;
    int          frameCount = 0;

    // reference model state mirrors the register writes.
    logic [11:0] romModel [ROM_DEPTH];
    int mStart;
    int mCount;
    int mLoopStart;
    int mLoopEnd;
    int mVol;
    int mPos;
    int mLast;
    bit mLoop;
    bit mMono;
    bit mLeft;
    bit mPlay;

    audioChannelTop DUT (
        .clk_25mhz   (clk_25mhz),
        .i_arstN     (i_arstN),
        .i_regWe     (i_regWe),
        .i_regSel    (i_regSel),
        .i_regData   (i_regData),
        .audio_bclk  (audio_bclk),
        .audio_lrclk (audio_lrclk),
        .audio_din   (audio_din),
        .o_playing   (o_playing)
    );

    initial begin
        clk_25mhz = 1'b0;
        forever #20 clk_25mhz = ~clk_25mhz;
    end

    // a word completes when lrclk flips and the right word ends the frame.
    always @(posedge audio_bclk) begin
        shiftIn = {shiftIn[14:0], audio_din};
        bitsInSlot++;
        if (audio_lrclk != prevLr) begin
            if (slotSync) begin
                assert (bitsInSlot == SLOT_BITS) else begin
                    errors++;
                    $display("CHECK FAILED: audio_lrclk slot length expected 0x%h got 0x%h",
                             SLOT_BITS, bitsInSlot);
                end
            end
            slotSync = 1'b1;
            bitsInSlot = 0;
            if (!prevLr) begin
                gotLeft = shiftIn;
            end else begin
                gotRight = shiftIn;
                frameCount++;
            end
        end
        prevLr = audio_lrclk;
    end

    function automatic int clampSample(int value);
        if (value > 32767) return 32767;
        if (value < -32768) return -32768;
        return value;
    endfunction

    task automatic modelDecode(output int outVal);
        int addr;
        int delta;
        if (!mPlay) begin
            outVal = 0;
        end else begin
            addr  = (mStart + mPos) % ROM_DEPTH;
            delta = romModel[addr];
            if (delta >= 2048) delta -= 4096; // 12-bit two's complement.
            mLast  = clampSample(mLast + delta);
            outVal = clampSample((mLast * mVol) >>> VOL_SHIFT);
            if (mLoop && mPos == mLoopEnd) begin
                mPos = mLoopStart;
            end else if (!mLoop && mPos + 1 == mCount) begin
                mPlay = 1'b0;
            end else begin
                mPos++;
            end
        end
    endtask

    task automatic writeReg(regSel_t sel, logic [REG_DATA_W-1:0] data);
        @(posedge clk_25mhz);
        #2;
        i_regWe   = 1'b1;
        i_regSel  = sel;
        i_regData = data;
        @(posedge clk_25mhz);
        #2;
        i_regWe = 1'b0;
    endtask

    task automatic waitFrame();
        int startCount;
        int cycles;
        startCount = frameCount;
        cycles = 0;
        while (frameCount == startCount && cycles <= FRAME_TIMEOUT) begin
            @(posedge clk_25mhz);
            cycles++;
        end
        if (frameCount == startCount) begin
            $display("timeout: no complete I2S frame within %0d clock cycles", FRAME_TIMEOUT);
            $display("Simulation failed");
            $finish;
        end
    endtask

    task automatic checkFrame(int expL, int expR);
        assert (gotLeft == 16'(expL)) else begin
            errors++;
            $display("CHECK FAILED: audio_din left slot expected 0x%04h got 0x%04h",
                     16'(expL), gotLeft);
        end
        assert (gotRight == 16'(expR)) else begin
            errors++;
            $display("CHECK FAILED: audio_din right slot expected 0x%04h got 0x%04h",
                     16'(expR), gotRight);
        end
    endtask

    task automatic checkPlaying(bit expected);
        assert (o_playing == expected) else begin
            errors++;
            $display("CHECK FAILED: o_playing expected 0x%h got 0x%h", expected, o_playing);
        end
    endtask

    task automatic setupVoice(int start, int count, int loopS, int loopE, int vol,
                              bit loop, bit mono, bit left, int pos, int last);
        writeReg(REG_START_ADDR, 24'(start));
        writeReg(REG_SAMPLE_COUNT, 24'(count));
        writeReg(REG_LOOP_START, 24'(loopS));
        writeReg(REG_LOOP_END, 24'(loopE));
        writeReg(REG_VOLUME, 24'(vol));
        writeReg(REG_LOOPING, 24'(loop));
        writeReg(REG_MONO, 24'(mono));
        writeReg(REG_LEFT, 24'(left));
        writeReg(REG_CUR_POS, 24'(pos));
        writeReg(REG_LAST_SAMPLE, {8'h00, 16'(last)});
        mStart = start;
        mCount = count;
        mLoopStart = loopS;
        mLoopEnd = loopE;
        mVol = vol;
        mLoop = loop;
        mMono = mono;
        mLeft = left;
        mPos = pos;
        mLast = last;
    endtask

    // frame k after the two silent ones carries decode k.
    task automatic playRun(int n);
        int outQ[$];
        bit playQ[$];
        int outVal;
        int expL;
        int expR;
        mPlay = 1'b1;
        for (int i = 0; i < n + 2; i++) begin
            modelDecode(outVal);
            outQ.push_back(outVal);
            playQ.push_back(mPlay);
        end
        waitFrame();
        checkFrame(0, 0);
        writeReg(REG_PLAYING, 24'd1);
        repeat (2) begin
            waitFrame();
            checkFrame(0, 0);
        end
        for (int i = 0; i < n + 2; i++) begin
            waitFrame();
            if (mMono) begin
                expL = outQ[i];
                expR = outQ[i];
            end else if (mLeft) begin
                expL = outQ[i];
                expR = 0;
            end else begin
                expL = 0;
                expR = outQ[i];
            end
            checkFrame(expL, expR);
            if (i < n) checkPlaying(playQ[i + 2]); // voice runs two decodes ahead.
            if (i == n - 1) writeReg(REG_PLAYING, 24'd0);
        end
        repeat (2) begin
            waitFrame();
            checkFrame(0, 0);
        end
        checkPlaying(1'b0);
    endtask

    initial begin
        int seed;
        int randStart;
        int loopS;
        int loopE;
        int randLast;
        seed = 17130;
        i_arstN   = 1'b1;
        i_regWe   = 1'b0;
        i_regSel  = REG_START_ADDR;
        i_regData = '0;
        $readmemh("deltas.hex", romModel);
        #2 i_arstN = 1'b0;
        repeat (2) @(posedge clk_25mhz);
        #2 i_arstN = 1'b1;

        repeat (3) begin // idle after reset.
            waitFrame();
            checkFrame(0, 0);
            checkPlaying(1'b0);
        end

        // mono at unity gain into positive saturation.
        setupVoice(0, 64, 0, 0, 128, 1'b0, 1'b1, 1'b0, 0, 30000);
        playRun(10);

        // stereo at half volume with left then right.
        setupVoice(32, 64, 0, 0, 64, 1'b0, 1'b0, 1'b1, 0, -1000);
        playRun(6);
        setupVoice(32, 64, 0, 0, 64, 1'b0, 1'b0, 1'b0, 0, -1000);
        playRun(6);

        randStart = $unsigned($random(seed)) % ROM_DEPTH;
        loopS     = $unsigned($random(seed)) % 4;
        loopE     = loopS + 2 + $unsigned($random(seed)) % 3;
        randLast  = $random(seed) % 8192;
        setupVoice(randStart, 64, loopS, loopE, 96, 1'b1, 1'b1, 1'b0, loopS, randLast);
        playRun(14);

        // five samples then the voice stops by itself.
        setupVoice(16, 5, 0, 0, 200, 1'b0, 1'b1, 1'b0, 0, 0);
        playRun(8);

        $display("errors: %0d word checks, %0d protocol assertions",
                 errors, DUT.u_checker.failCount);
        if (errors == 0 && DUT.u_checker.failCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- deltas.hex
// one 12-bit signed delta per line in hex, address 0 first.
7FF
7FF
400
800
F00
123
0A5
E80
7F0
010
FFF
800
300
C40
055
1F0
200
7FF
600
7FF
5A0
F10
090
D00
333
0CC
F33
444
B80
020
7C0
880
100
F80
250
E20
3C0
060
A00
1E0
0F0
FA0
2A0
D60
150
7A0
820
0B0
045
F55
3A3
C5C
7FF
001
800
E00
2C0
1D0
EB0
0AA
F11
4D4
B2B
6E6

//--- sim.f
audioPkg.sv
channelRegs.sv
sampleRom.sv
channelVoice.sv
i2sTransmitter.sv
audioChannelTop.sv
audioChannel_checker.sv
tb_audioChannel.sv
